/* source/decode_pkg.sv */
/*
 * Decode stage 0 shared definitions
 * Fetch window and decoded record layouts, prefix byte codes and
 * immediate size classes used by the decoder and its testbench
 */
package decode_pkg;

   // Window and instruction geometry
   localparam int WINDOW_BYTES   = 16;
   localparam int ADDR_W         = 32;
   localparam int MAX_PREFIX     = 3;
   localparam int NUM_LANES      = MAX_PREFIX + 1;
   localparam int MAX_INSN_BYTES = 15;

   // Legacy prefix bytes
   localparam logic [7:0] PFX_OPSIZE = 8'h66;
   localparam logic [7:0] PFX_REP    = 8'hF3;
   localparam logic [7:0] PFX_REPNE  = 8'hF2;
   localparam logic [7:0] PFX_LOCK   = 8'hF0;
   localparam logic [7:0] PFX_CS     = 8'h2E;
   localparam logic [7:0] PFX_SS     = 8'h36;
   localparam logic [7:0] PFX_DS     = 8'h3E;
   localparam logic [7:0] PFX_ES     = 8'h26;
   localparam logic [7:0] PFX_FS     = 8'h64;
   localparam logic [7:0] PFX_GS     = 8'h65;

   // Opcode bytes with special handling
   localparam logic [7:0] OPC_ESCAPE = 8'h0F;
   localparam logic [7:0] OPC_HLT    = 8'hF4;

   // Immediate size class from the opcode table
   // IMM_Z is 2 or 4 bytes depending on the operand-size prefix
   typedef enum logic [1:0] {
      IMM_NONE,
      IMM_8,
      IMM_16,
      IMM_Z
   } imm_class_t;

   // Window as handed over by fetch, byte 0 in the top byte
   typedef struct packed {
      logic [8*WINDOW_BYTES-1:0] bytes;
      logic [4:0]                valid_bytes;
      logic [ADDR_W-1:0]         pc;
      logic                      branch_taken;
   } fetch_window_t;

   // Classification of one window byte
   typedef struct packed {
      logic is_prefix;
      logic is_size_prefix;
      logic is_escape;
   } byte_class_t;

   // Decoded instruction record
   typedef struct packed {
      logic [23:0]       prefix;
      logic [1:0]        prefix_bytes;
      logic              size_override;
      logic [15:0]       opcode;
      logic [1:0]        opcode_bytes;
      logic              has_modrm;
      logic [7:0]        modrm;
      logic              has_sib;
      logic [2:0]        disp_bytes;
      logic [2:0]        imm_bytes;
      // Displacement first, then immediate, left-aligned
      logic [63:0]       displace_n_imm;
      logic [3:0]        length;
      logic              incomplete;
      logic              halt_insn;
      logic [ADDR_W-1:0] pc;
      logic              branch_taken;
   } decoded_insn_t;

endpackage

/* source/pipe_reg.sv */
/*
 * One-entry valid/ready pipeline register
 * Full throughput, flushable, payload type set by parameter
 */
`timescale 1ns/1ns

module pipe_reg #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     flush,
   input  logic     in_valid,
   input  payload_t in_data,
   output logic     in_ready,
   output logic     out_valid,
   output payload_t out_data,
   input  logic     out_ready
);

   logic     full;
   payload_t data_q;

   // Accept when empty or when the held entry leaves this cycle
   assign in_ready = !full || out_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         full <= 1'b0;
      end else if (flush) begin
         full <= 1'b0;
      end else if (in_ready) begin
         full <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         data_q <= in_data;
      end
   end

   assign out_valid = full;
   assign out_data  = data_q;

   // A stalled entry must not change under the consumer
   assert property (@(posedge clk) disable iff (!arst_n)
      out_valid && !out_ready |=> $stable(out_data));

endmodule

/* source/prefix_classifier.sv */
/*
 * Prefix classifier lane
 * Flags one window byte as legacy prefix, operand-size prefix or 0F escape
 */
`timescale 1ns/1ns

module prefix_classifier
   import decode_pkg::*;
(
   input  logic [7:0]  window_byte,
   output byte_class_t byte_class
);

   always_comb begin
      byte_class = '0;

      // Any of the ten legacy prefixes
      case (window_byte)
         PFX_OPSIZE,
         PFX_REP,
         PFX_REPNE,
         PFX_LOCK,
         PFX_CS,
         PFX_SS,
         PFX_DS,
         PFX_ES,
         PFX_FS,
         PFX_GS: begin
            byte_class.is_prefix = 1'b1;
         end
         default: begin
            byte_class.is_prefix = 1'b0;
         end
      endcase

      // Operand size only shrinks z immediates
      byte_class.is_size_prefix = (window_byte == PFX_OPSIZE);

      // Only meaningful on the lane that holds the opcode
      byte_class.is_escape = (window_byte == OPC_ESCAPE);
   end

endmodule

/* source/insn_length_decoder.sv */
/*
 * Instruction length decoder
 * Builds the decoded record and length from the window and lane classes,
 * and holds the sticky halt state after an accepted HLT
 */
`timescale 1ns/1ns

module insn_length_decoder
   import decode_pkg::*;
(
   input  logic          clk,
   input  logic          arst_n,
   input  logic          flush,
   input  logic          win_valid,
   input  fetch_window_t win,
   input  byte_class_t   lane_class [NUM_LANES],
   output logic          win_ready,
   output logic          dec_valid,
   output decoded_insn_t dec,
   input  logic          dec_ready,
   output logic          halt
);

   logic [1:0]                prefix_bytes;
   logic                      size_override;
   logic                      escape;
   logic [8*WINDOW_BYTES-1:0] opc_win;
   logic [7:0]                op0;
   logic [7:0]                op1;
   logic [1:0]                opcode_bytes;
   logic [2:0]                opc_end;
   logic                      has_modrm;
   imm_class_t                imm_class;
   logic [2:0]                imm_bytes;
   logic [8*WINDOW_BYTES-1:0] modrm_win;
   logic [7:0]                modrm;
   logic [7:0]                sib;
   logic                      has_sib;
   logic [2:0]                disp_bytes;
   logic [2:0]                head_bytes;
   logic [3:0]                dni_bytes;
   logic [8*WINDOW_BYTES-1:0] dni_win;
   logic [63:0]               dni_mask;
   logic [4:0]                len_sum;
   logic                      halt_q;

   // Leading run of prefix lanes, capped at MAX_PREFIX
   always_comb begin
      prefix_bytes  = 2'd0;
      size_override = 1'b0;
      for (int i = 0; i < MAX_PREFIX; i++) begin
         if (lane_class[i].is_prefix && prefix_bytes == 2'(i)) begin
            prefix_bytes  = prefix_bytes + 2'd1;
            size_override = size_override | lane_class[i].is_size_prefix;
         end
      end
   end

   // Opcode sits on the lane right after the prefixes
   assign escape       = lane_class[prefix_bytes].is_escape;
   assign opc_win      = win.bytes << {prefix_bytes, 3'b000};
   assign op0          = opc_win[8*WINDOW_BYTES-1 -: 8];
   assign op1          = opc_win[8*WINDOW_BYTES-9 -: 8];
   assign opcode_bytes = escape ? 2'd2 : 2'd1;
   assign opc_end      = {1'b0, prefix_bytes} + {1'b0, opcode_bytes};

   // Opcode table
   always_comb begin
      has_modrm = 1'b0;
      imm_class = IMM_NONE;
      if (escape) begin
         // Jcc rel32 has no ModRM
         if (op1[7:4] == 4'h8) begin
            imm_class = IMM_Z;
         end else begin
            has_modrm = 1'b1;
         end
      end else begin
         case (op0) inside
            [8'h00:8'h03], [8'h08:8'h0B], [8'h20:8'h23], [8'h28:8'h2B],
            [8'h30:8'h33], [8'h38:8'h3B], [8'h88:8'h8B], 8'h8D: begin
               has_modrm = 1'b1;
            end
            8'h80, 8'h83, 8'hC0, 8'hC1, 8'hC6, 8'h6B: begin
               has_modrm = 1'b1;
               imm_class = IMM_8;
            end
            8'h81, 8'hC7, 8'h69: begin
               has_modrm = 1'b1;
               imm_class = IMM_Z;
            end
            8'h04, 8'h0C, 8'h24, 8'h2C, 8'h34, 8'h3C, 8'h6A, 8'hEB,
            [8'h70:8'h7F], [8'hB0:8'hB7]: begin
               imm_class = IMM_8;
            end
            8'h05, 8'h0D, 8'h25, 8'h2D, 8'h35, 8'h3D, 8'h68, 8'hE8, 8'hE9,
            [8'hB8:8'hBF]: begin
               imm_class = IMM_Z;
            end
            8'hC2: begin
               imm_class = IMM_16;
            end
            default: begin
               imm_class = IMM_NONE;
            end
         endcase
      end
   end

   always_comb begin
      case (imm_class)
         IMM_8:   imm_bytes = 3'd1;
         IMM_16:  imm_bytes = 3'd2;
         IMM_Z:   imm_bytes = size_override ? 3'd2 : 3'd4;
         default: imm_bytes = 3'd0;
      endcase
   end

   // ModRM and SIB follow the opcode
   assign modrm_win = win.bytes << {opc_end, 3'b000};
   assign modrm     = has_modrm ? modrm_win[8*WINDOW_BYTES-1 -: 8] : 8'h00;
   assign sib       = modrm_win[8*WINDOW_BYTES-9 -: 8];
   assign has_sib   = has_modrm && modrm[7:6] != 2'b11 && modrm[2:0] == 3'd4;

   // Displacement size from mod, rm and SIB base
   always_comb begin
      disp_bytes = 3'd0;
      if (has_modrm) begin
         case (modrm[7:6])
            2'b01: disp_bytes = 3'd1;
            2'b10: disp_bytes = 3'd4;
            2'b00: begin
               if (modrm[2:0] == 3'd5 || (has_sib && sib[2:0] == 3'd5)) begin
                  disp_bytes = 3'd4;
               end
            end
            default: disp_bytes = 3'd0;
         endcase
      end
   end

   // Left-align displacement and immediate, clear the bytes past them
   assign head_bytes = opc_end + {2'b00, has_modrm} + {2'b00, has_sib};
   assign dni_win    = win.bytes << {head_bytes, 3'b000};
   assign dni_bytes  = {1'b0, disp_bytes} + {1'b0, imm_bytes};
   assign dni_mask   = ~({64{1'b1}} >> {dni_bytes, 3'b000});
   assign len_sum    = {2'b00, head_bytes} + {1'b0, dni_bytes};

   always_comb begin
      dec                = '0;
      dec.prefix         = win.bytes[8*WINDOW_BYTES-1 -: 24];
      dec.prefix_bytes   = prefix_bytes;
      dec.size_override  = size_override;
      dec.opcode         = escape ? {op0, op1} : {op0, 8'h00};
      dec.opcode_bytes   = opcode_bytes;
      dec.has_modrm      = has_modrm;
      dec.modrm          = modrm;
      dec.has_sib        = has_sib;
      dec.disp_bytes     = disp_bytes;
      dec.imm_bytes      = imm_bytes;
      dec.displace_n_imm = dni_win[8*WINDOW_BYTES-1 -: 64] & dni_mask;
      dec.length         = len_sum[3:0];
      dec.incomplete     = len_sum > win.valid_bytes;
      dec.halt_insn      = !escape && op0 == OPC_HLT;
      dec.pc             = win.pc;
      dec.branch_taken   = win.branch_taken;
   end

   // Sticky halt, set when the HLT record is accepted downstream
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         halt_q <= 1'b0;
      end else if (flush) begin
         halt_q <= 1'b0;
      end else if (dec_valid && dec_ready && dec.halt_insn) begin
         halt_q <= 1'b1;
      end
   end

   assign halt      = halt_q;
   assign dec_valid = win_valid && !halt_q;
   assign win_ready = dec_ready && !halt_q;

   assert property (@(posedge clk) disable iff (!arst_n)
      win_valid |-> len_sum <= 5'(MAX_INSN_BYTES));

   // A window waiting behind the halt is held, not consumed
   assert property (@(posedge clk) disable iff (!arst_n)
      halt && win_valid && !flush |=> $stable(win));

endmodule

/* source/decode_stage_0.sv */
/*
 * Decode stage 0 top level
 * Registered fetch window, four prefix lanes, length decoder and
 * registered decoded record on plain valid/ready ports
 */
`timescale 1ns/1ns

module decode_stage_0
   import decode_pkg::*;
(
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      flush,
   output logic                      halt,

   // Fetch side
   input  logic                      f_valid,
   output logic                      f_ready,
   input  logic [8*WINDOW_BYTES-1:0] f_instruction,
   input  logic [4:0]                f_valid_bytes,
   input  logic [ADDR_W-1:0]         f_pc,
   input  logic                      f_branch_taken,

   // Stage 0 record
   output logic                      s0_valid,
   input  logic                      s0_ready,
   output logic [23:0]               s0_prefix,
   output logic [1:0]                s0_prefix_bytes,
   output logic                      s0_size_override,
   output logic [15:0]               s0_opcode,
   output logic [1:0]                s0_opcode_bytes,
   output logic                      s0_has_modrm,
   output logic [7:0]                s0_modrm,
   output logic                      s0_has_sib,
   output logic [2:0]                s0_disp_bytes,
   output logic [2:0]                s0_imm_bytes,
   output logic [63:0]               s0_displace_n_imm,
   output logic [3:0]                s0_length,
   output logic                      s0_incomplete,
   output logic                      s0_halt_insn,
   output logic [ADDR_W-1:0]         s0_pc,
   output logic                      s0_branch_taken
);

   fetch_window_t f_win;
   fetch_window_t win;
   logic          win_valid;
   logic          win_ready;
   byte_class_t   lane_class [NUM_LANES];
   decoded_insn_t dec;
   logic          dec_valid;
   logic          dec_ready;
   decoded_insn_t s0_rec;

   assign f_win.bytes        = f_instruction;
   assign f_win.valid_bytes  = f_valid_bytes;
   assign f_win.pc           = f_pc;
   assign f_win.branch_taken = f_branch_taken;

   pipe_reg #(.payload_t(fetch_window_t)) fetch_pipe_reg (
      .clk       (clk),
      .arst_n    (arst_n),
      .flush     (flush),
      .in_valid  (f_valid),
      .in_data   (f_win),
      .in_ready  (f_ready),
      .out_valid (win_valid),
      .out_data  (win),
      .out_ready (win_ready)
   );

   // Lane g looks at window byte g
   for (genvar g = 0; g < NUM_LANES; g++) begin : gen_lane
      prefix_classifier lane_i (
         .window_byte (win.bytes[8*(WINDOW_BYTES-g)-1 -: 8]),
         .byte_class  (lane_class[g])
      );
   end

   insn_length_decoder decoder_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .flush      (flush),
      .win_valid  (win_valid),
      .win        (win),
      .lane_class (lane_class),
      .win_ready  (win_ready),
      .dec_valid  (dec_valid),
      .dec        (dec),
      .dec_ready  (dec_ready),
      .halt       (halt)
   );

   pipe_reg #(.payload_t(decoded_insn_t)) s0_pipe_reg (
      .clk       (clk),
      .arst_n    (arst_n),
      .flush     (flush),
      .in_valid  (dec_valid),
      .in_data   (dec),
      .in_ready  (dec_ready),
      .out_valid (s0_valid),
      .out_data  (s0_rec),
      .out_ready (s0_ready)
   );

   assign s0_prefix         = s0_rec.prefix;
   assign s0_prefix_bytes   = s0_rec.prefix_bytes;
   assign s0_size_override  = s0_rec.size_override;
   assign s0_opcode         = s0_rec.opcode;
   assign s0_opcode_bytes   = s0_rec.opcode_bytes;
   assign s0_has_modrm      = s0_rec.has_modrm;
   assign s0_modrm          = s0_rec.modrm;
   assign s0_has_sib        = s0_rec.has_sib;
   assign s0_disp_bytes     = s0_rec.disp_bytes;
   assign s0_imm_bytes      = s0_rec.imm_bytes;
   assign s0_displace_n_imm = s0_rec.displace_n_imm;
   assign s0_length         = s0_rec.length;
   assign s0_incomplete     = s0_rec.incomplete;
   assign s0_halt_insn      = s0_rec.halt_insn;
   assign s0_pc             = s0_rec.pc;
   assign s0_branch_taken   = s0_rec.branch_taken;

endmodule

/* verification/decode_stage_0_tb.sv */
/*
 * Decode stage 0 testbench
 * Table-driven windows through the fetch handshake, checked against a
 * reference decoder, with random back-pressure and a halt and flush sequence
 */
`timescale 1ns/1ns

module decode_stage_0_tb
   import decode_pkg::*;
();

   localparam int RESET_CYCLES = 16;
   localparam int NUM_ROWS     = 36;
   localparam int HLT_ROW      = 32;
   localparam int QUIET_CYCLES = 20;
   localparam int GAP_MARGIN   = 64;
   localparam int CYCLE_LIMIT  = RESET_CYCLES + 4 * NUM_ROWS + GAP_MARGIN;

   logic                      clk;
   logic                      arst_n;
   logic                      flush;
   logic                      halt;
   logic                      f_valid;
   logic                      f_ready;
   logic [8*WINDOW_BYTES-1:0] f_instruction;
   logic [4:0]                f_valid_bytes;
   logic [ADDR_W-1:0]         f_pc;
   logic                      f_branch_taken;
   logic                      s0_valid;
   logic                      s0_ready;
   logic [23:0]               s0_prefix;
   logic [1:0]                s0_prefix_bytes;
   logic                      s0_size_override;
   logic [15:0]               s0_opcode;
   logic [1:0]                s0_opcode_bytes;
   logic                      s0_has_modrm;
   logic [7:0]                s0_modrm;
   logic                      s0_has_sib;
   logic [2:0]                s0_disp_bytes;
   logic [2:0]                s0_imm_bytes;
   logic [63:0]               s0_displace_n_imm;
   logic [3:0]                s0_length;
   logic                      s0_incomplete;
   logic                      s0_halt_insn;
   logic [ADDR_W-1:0]         s0_pc;
   logic                      s0_branch_taken;
   decoded_insn_t             s0_got;

   fetch_window_t rows [NUM_ROWS];
   logic [3:0]    row_len [NUM_ROWS];
   int            row_count;
   decoded_insn_t exp_q [$];
   int            row_q [$];
   int            seed = 56;
   bit            ready_random;
   int            tests;
   int            errors;
   int            cycles;

   decode_stage_0 dut_i (.*);

   assign s0_got = {s0_prefix, s0_prefix_bytes, s0_size_override, s0_opcode, s0_opcode_bytes,
                    s0_has_modrm, s0_modrm, s0_has_sib, s0_disp_bytes, s0_imm_bytes,
                    s0_displace_n_imm, s0_length, s0_incomplete, s0_halt_insn, s0_pc,
                    s0_branch_taken};

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic bit is_prefix_byte(input logic [7:0] v);
      return v inside {8'h66, 8'hF3, 8'hF2, 8'hF0, 8'h2E, 8'h36, 8'h3E, 8'h26, 8'h64, 8'h65};
   endfunction

   function automatic bit op_has_modrm(input logic [7:0] op);
      return op inside {[8'h00:8'h03], [8'h08:8'h0B], [8'h20:8'h23], [8'h28:8'h2B],
                        [8'h30:8'h33], [8'h38:8'h3B], [8'h88:8'h8B], 8'h8D, 8'h80, 8'h83,
                        8'hC0, 8'hC1, 8'hC6, 8'h6B, 8'h81, 8'hC7, 8'h69};
   endfunction

   // Immediate size of a one-byte opcode, -1 stands for z
   function automatic int op_imm_size(input logic [7:0] op);
      if (op inside {8'h80, 8'h83, 8'hC0, 8'hC1, 8'hC6, 8'h6B, 8'h04, 8'h0C, 8'h24, 8'h2C,
                     8'h34, 8'h3C, 8'h6A, 8'hEB, [8'h70:8'h7F], [8'hB0:8'hB7]})
         return 1;
      if (op inside {8'h81, 8'hC7, 8'h69, 8'h05, 8'h0D, 8'h25, 8'h2D, 8'h35, 8'h3D, 8'h68,
                     8'hE8, 8'hE9, [8'hB8:8'hBF]})
         return -1;
      if (op == 8'hC2)
         return 2;
      return 0;
   endfunction

   // Reference decoder, walks the window byte by byte
   function automatic decoded_insn_t ref_decode(input fetch_window_t w);
      decoded_insn_t r;
      logic [7:0]    b [WINDOW_BYTES+8];
      int            pos;
      int            disp;
      int            imm;
      logic [7:0]    m;
      r = '0;
      for (int k = 0; k < WINDOW_BYTES; k++) begin
         b[k] = w.bytes[8*(WINDOW_BYTES-1-k) +: 8];
      end
      // Bytes past the window read as zero
      for (int k = WINDOW_BYTES; k < WINDOW_BYTES + 8; k++) begin
         b[k] = 8'h00;
      end
      r.prefix = {b[0], b[1], b[2]};
      pos = 0;
      while (pos < MAX_PREFIX && is_prefix_byte(b[pos])) begin
         r.size_override |= (b[pos] == 8'h66);
         pos++;
      end
      r.prefix_bytes = 2'(pos);
      imm = 0;
      if (b[pos] == 8'h0F) begin
         r.opcode       = {b[pos], b[pos+1]};
         r.opcode_bytes = 2'd2;
         if (b[pos+1][7:4] == 4'h8) begin
            imm = -1;
         end else begin
            r.has_modrm = 1'b1;
         end
      end else begin
         r.opcode       = {b[pos], 8'h00};
         r.opcode_bytes = 2'd1;
         r.halt_insn    = (b[pos] == 8'hF4);
         r.has_modrm    = op_has_modrm(b[pos]);
         imm            = op_imm_size(b[pos]);
      end
      if (imm < 0) begin
         imm = r.size_override ? 2 : 4;
      end
      pos += r.opcode_bytes;
      disp = 0;
      if (r.has_modrm) begin
         m       = b[pos];
         r.modrm = m;
         pos++;
         if (m[7:6] != 2'b11 && m[2:0] == 3'd4) begin
            r.has_sib = 1'b1;
            pos++;
         end
         if (m[7:6] == 2'b01) begin
            disp = 1;
         end else if (m[7:6] == 2'b10) begin
            disp = 4;
         end else if (m[7:6] == 2'b00 &&
                      (m[2:0] == 3'd5 || (r.has_sib && b[pos-1][2:0] == 3'd5))) begin
            disp = 4;
         end
      end
      r.disp_bytes = 3'(disp);
      r.imm_bytes  = 3'(imm);
      for (int k = 0; k < disp + imm; k++) begin
         r.displace_n_imm[63-8*k -: 8] = b[pos+k];
      end
      r.length       = 4'(pos + disp + imm);
      r.incomplete   = (pos + disp + imm) > w.valid_bytes;
      r.pc           = w.pc;
      r.branch_taken = w.branch_taken;
      return r;
   endfunction

   // Head bytes given right-aligned, the rest of the window gets filler
   task automatic add_row(input int n, input logic [127:0] head, input logic [4:0] valid,
                          input logic [3:0] len);
      fetch_window_t w;
      w.bytes = head << (8 * (WINDOW_BYTES - n));
      for (int k = n; k < WINDOW_BYTES; k++) begin
         w.bytes[8*(WINDOW_BYTES-1-k) +: 8] = 8'hC0 + 8'(k);
      end
      w.valid_bytes      = valid;
      w.pc               = 32'h0040_1000 + 32'(row_count * 16);
      w.branch_taken     = (row_count % 3) == 1;
      rows[row_count]    = w;
      row_len[row_count] = len;
      row_count++;
   endtask

   task automatic build_table();
      row_count = 0;
      add_row(5, 40'h05_78_56_34_12, 5'd16, 4'd5);
      add_row(4, 32'h66_05_34_12, 5'd16, 4'd4);
      add_row(2, 16'h01_D8, 5'd16, 4'd2);
      add_row(2, 16'h8B_00, 5'd16, 4'd2);
      add_row(3, 24'h03_45_08, 5'd16, 4'd3);
      add_row(6, 48'h8B_80_44_33_22_11, 5'd16, 4'd6);
      add_row(6, 48'h8B_05_78_56_34_12, 5'd16, 4'd6);
      add_row(3, 24'h8B_04_24, 5'd16, 4'd3);
      add_row(7, 56'h8B_04_25_78_56_34_12, 5'd16, 4'd7);
      add_row(4, 32'h8B_44_24_08, 5'd16, 4'd4);
      add_row(7, 56'h8B_84_24_00_01_00_00, 5'd16, 4'd7);
      add_row(3, 24'h83_C0_01, 5'd16, 4'd3);
      add_row(10, 80'h81_80_44_33_22_11_78_56_34_12, 5'd16, 4'd10);
      add_row(5, 40'h66_81_C0_34_12, 5'd16, 4'd5);
      add_row(7, 56'hC6_05_78_56_34_12_AB, 5'd16, 4'd7);
      add_row(2, 16'h6A_7F, 5'd16, 4'd2);
      add_row(2, 16'hEB_FE, 5'd16, 4'd2);
      add_row(5, 40'hE8_00_10_00_00, 5'd16, 4'd5);
      add_row(3, 24'hC2_08_00, 5'd16, 4'd3);
      add_row(5, 40'hB8_01_00_00_00, 5'd16, 4'd5);
      add_row(5, 40'h26_66_B8_34_12, 5'd16, 4'd5);
      add_row(6, 48'h0F_84_10_00_00_00, 5'd16, 4'd6);
      add_row(5, 40'h66_0F_84_10_00, 5'd16, 4'd5);
      add_row(3, 24'h0F_AF_C3, 5'd16, 4'd3);
      add_row(8, 64'hF0_0F_B1_0D_78_56_34_12, 5'd16, 4'd8);
      add_row(12, 96'h2E_3E_66_81_84_24_00_01_00_00_34_12, 5'd16, 4'd12);
      add_row(4, 32'hF3_F2_F0_26, 5'd16, 4'd4);
      add_row(7, 56'h64_8B_0D_78_56_34_12, 5'd16, 4'd7);
      add_row(1, 8'h90, 5'd16, 4'd1);
      add_row(6, 48'h69_C0_10_00_00_00, 5'd16, 4'd6);
      // Windows cut short of the instruction
      add_row(10, 80'h81_80_44_33_22_11_78_56_34_12, 5'd6, 4'd10);
      add_row(3, 24'h05_78_56, 5'd3, 4'd5);
      add_row(1, 8'hF4, 5'd16, 4'd1);
      add_row(2, 16'hB0_12, 5'd16, 4'd2);
      add_row(3, 24'h0F_B6_C1, 5'd16, 4'd3);
      add_row(4, 32'h8B_4C_24_04, 5'd16, 4'd4);
      if (row_count != NUM_ROWS) begin
         $display("stimulus table holds %0d rows instead of %0d", row_count, NUM_ROWS);
         errors++;
      end
   endtask

   task automatic compare_field(input string name, input logic [63:0] got,
                                input logic [63:0] exp, inout int bad);
      if (got !== exp) begin
         $display("MISMATCH s0_%s: got %h expected %h", name, got, exp);
         bad++;
      end
   endtask

   task automatic check_insn(input int row, input decoded_insn_t got, input decoded_insn_t exp);
      int bad;
      bad = 0;
      tests++;
      compare_field("prefix", got.prefix, exp.prefix, bad);
      compare_field("prefix_bytes", got.prefix_bytes, exp.prefix_bytes, bad);
      compare_field("size_override", got.size_override, exp.size_override, bad);
      compare_field("opcode", got.opcode, exp.opcode, bad);
      compare_field("opcode_bytes", got.opcode_bytes, exp.opcode_bytes, bad);
      compare_field("has_modrm", got.has_modrm, exp.has_modrm, bad);
      compare_field("modrm", got.modrm, exp.modrm, bad);
      compare_field("has_sib", got.has_sib, exp.has_sib, bad);
      compare_field("disp_bytes", got.disp_bytes, exp.disp_bytes, bad);
      compare_field("imm_bytes", got.imm_bytes, exp.imm_bytes, bad);
      compare_field("displace_n_imm", got.displace_n_imm, exp.displace_n_imm, bad);
      compare_field("length", got.length, exp.length, bad);
      compare_field("incomplete", got.incomplete, exp.incomplete, bad);
      compare_field("halt_insn", got.halt_insn, exp.halt_insn, bad);
      compare_field("pc", got.pc, exp.pc, bad);
      compare_field("branch_taken", got.branch_taken, exp.branch_taken, bad);
      if (bad != 0) begin
         errors++;
         $display("row %0d: FAIL, %0d fields wrong", row, bad);
      end else begin
         $display("row %0d: ok, length %0d", row, got.length);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      tests++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH %s: got %h expected %h", name, got, exp);
      end else begin
         $display("%s: ok", name);
      end
   endtask

   // Offer one row on the fetch side, with an occasional idle cycle first
   task automatic send_row(input int idx, input bit expect_out);
      decoded_insn_t model;
      if (($random(seed) & 3) == 0) begin
         @(negedge clk);
         f_valid = 1'b0;
      end
      @(negedge clk);
      f_valid        = 1'b1;
      f_instruction  = rows[idx].bytes;
      f_valid_bytes  = rows[idx].valid_bytes;
      f_pc           = rows[idx].pc;
      f_branch_taken = rows[idx].branch_taken;
      @(posedge clk);
      while (!f_ready) begin
         @(posedge clk);
      end
      if (expect_out) begin
         model = ref_decode(rows[idx]);
         if (model.length !== row_len[idx]) begin
            errors++;
            $display("row %0d: table length %0d disagrees with reference decoder %0d",
                     idx, row_len[idx], model.length);
         end
         exp_q.push_back(model);
         row_q.push_back(idx);
      end
   endtask

   // Random back-pressure on the record side
   always @(negedge clk) begin
      if (ready_random) begin
         s0_ready = ($random(seed) & 3) != 0;
      end else begin
         s0_ready = 1'b1;
      end
   end

   always @(posedge clk) begin : monitor
      decoded_insn_t exp;
      int            row;
      if (arst_n && s0_valid && s0_ready) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("record with pc %h delivered when none was expected", s0_pc);
         end else begin
            exp = exp_q.pop_front();
            row = row_q.pop_front();
            check_insn(row, s0_got, exp);
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout after %0d cycles, %0d records still expected", cycles,
                  exp_q.size());
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   initial begin
      arst_n         = 1'b0;
      flush          = 1'b0;
      f_valid        = 1'b0;
      f_instruction  = '0;
      f_valid_bytes  = '0;
      f_pc           = '0;
      f_branch_taken = 1'b0;
      s0_ready       = 1'b1;
      ready_random   = 1'b0;
      tests          = 0;
      errors         = 0;
      cycles         = 0;
      build_table();
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      check_flag("f_ready after reset", f_ready, 1'b1);
      check_flag("s0_valid after reset", s0_valid, 1'b0);
      check_flag("halt after reset", halt, 1'b0);

      ready_random = 1'b1;
      for (int i = 0; i <= HLT_ROW; i++) begin
         send_row(i, 1'b1);
      end
      // Taken into the fetch register, then held behind the halt
      send_row(HLT_ROW + 1, 1'b0);
      @(negedge clk);
      f_valid = 1'b0;
      while (!(halt && exp_q.size() == 0)) begin
         @(posedge clk);
      end
      ready_random = 1'b0;
      repeat (QUIET_CYCLES) @(posedge clk);
      check_flag("halt held after HLT", halt, 1'b1);
      check_flag("f_ready while halted", f_ready, 1'b0);

      @(negedge clk);
      flush = 1'b1;
      @(negedge clk);
      flush = 1'b0;
      check_flag("halt after flush", halt, 1'b0);
      check_flag("f_ready after flush", f_ready, 1'b1);

      ready_random = 1'b1;
      for (int i = HLT_ROW + 1; i < NUM_ROWS; i++) begin
         send_row(i, 1'b1);
      end
      @(negedge clk);
      f_valid = 1'b0;
      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (4) @(posedge clk);

      $display("tests %0d, errors %0d, records outstanding %0d", tests, errors, exp_q.size());
      if (errors == 0 && exp_q.size() == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* vlog.f */
source/decode_pkg.sv
source/pipe_reg.sv
source/prefix_classifier.sv
source/insn_length_decoder.sv
source/decode_stage_0.sv
verification/decode_stage_0_tb.sv

/* Bender.yml */
package:
  name: decode_stage_0

sources:
  # RTL in compile order
  - files:
      - source/decode_pkg.sv
      - source/pipe_reg.sv
      - source/prefix_classifier.sv
      - source/insn_length_decoder.sv
      - source/decode_stage_0.sv

  # Testbench
  - target: test
    files:
      - verification/decode_stage_0_tb.sv
